/* src/reset_ctrl_pkg.sv */
package reset_ctrl_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // led pin modes and status display states

    // what the status led pin shows
    typedef enum logic [1:0] {
        LED_STATUS    = 2'd0,
        LED_OPT_RESET = 2'd1,
        LED_DC_RESET  = 2'd2,
        LED_OFF       = 2'd3
    } led_mode_e;

    // listed in decode priority, highest first
    typedef enum logic [2:0] {
        ST_PLL_WAIT    = 3'd0,
        ST_RESYNC      = 3'd1,
        ST_FORCE_GEN   = 3'd2,
        ST_READY       = 3'd3,
        ST_CONFIGURING = 3'd4
    } led_status_e;

    ////////////////////////////////////////////////////////////////////////////
    // timing defaults

    localparam int COUNT_WIDTH = 32;
    localparam int SYNC_STAGES = 2;

    // roughly one second of reset at the control clock rate
    localparam logic [31:0] HOLD_CYCLES_DEFAULT = 32'd32_000_000;

    // counter bits that set the glow and blink periods
    localparam int SLOW_GLOW_BIT = 26;
    localparam int FAST_GLOW_BIT = 22;
    localparam int BLINK_BIT     = 24;

endpackage

/* src/lock_event_detect.sv */
`timescale 1ns/100ps

module lock_event_detect import reset_ctrl_pkg::*; (
    input  logic control_clock,
    input  logic reset_dc,
    input  logic pll54_locked,
    input  logic pll_hdmi_locked,
    input  logic resync,
    input  logic force_generate,
    output logic pll_hdmi_ready,
    output logic resync_active,
    output logic force_gen_active,
    output logic pll54_lockloss,
    output logic pll_hdmi_lockloss,
    output logic resync_event
);

    // bit order: force_generate, resync, pll_hdmi_locked, pll54_locked
    logic [3:0] async_in;
    logic [3:0] sync_q [SYNC_STAGES];
    logic [3:0] sync_out;
    logic [2:0] prev_q;

    assign async_in = {force_generate, resync, pll_hdmi_locked, pll54_locked};
    assign sync_out = sync_q[SYNC_STAGES-1];

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                sync_q[i] <= '0;
            end
            prev_q            <= '0;
            pll54_lockloss    <= 1'b0;
            pll_hdmi_lockloss <= 1'b0;
            resync_event      <= 1'b0;
        end else begin
            sync_q[0] <= async_in;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
            prev_q <= sync_out[2:0];
            // falling edges of the locks, rising edge of resync
            pll54_lockloss    <= prev_q[0] & ~sync_out[0];
            pll_hdmi_lockloss <= prev_q[1] & ~sync_out[1];
            resync_event      <= ~prev_q[2] & sync_out[2];
        end
    end

    assign pll_hdmi_ready   = sync_out[1];
    assign resync_active    = sync_out[2];
    assign force_gen_active = sync_out[3];

    a_lockloss_single: assert property (@(posedge control_clock) disable iff (reset_dc)
        (pll54_lockloss |=> !pll54_lockloss) and (pll_hdmi_lockloss |=> !pll_hdmi_lockloss));

endmodule

/* src/reset_hold_timer.sv */
`timescale 1ns/100ps

module reset_hold_timer import reset_ctrl_pkg::*; #(
    parameter logic [COUNT_WIDTH-1:0] hold_cycles = HOLD_CYCLES_DEFAULT
) (
    input  logic control_clock,
    input  logic reset_dc,
    input  logic request,
    output logic hold_low
);

    logic [COUNT_WIDTH-1:0] hold_count;

    ////////////////////////////////////////////////////////////////////////////
    // hold counter

    // restarts on every request cycle, runs only while the line is held
    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            hold_count <= '0;
            hold_low   <= 1'b0;
        end else if (request) begin
            hold_count <= '0;
            hold_low   <= 1'b1;
        end else if (hold_low) begin
            hold_count <= hold_count + 1'b1;
            if (hold_count == hold_cycles) begin
                hold_low <= 1'b0;
            end
        end
    end

    // line must be pulled low right after a request
    a_request_holds: assert property (@(posedge control_clock) disable iff (reset_dc)
        request |=> hold_low);

endmodule

/* src/event_counters.sv */
`timescale 1ns/100ps

module event_counters import reset_ctrl_pkg::*; (
    input  logic                   control_clock,
    input  logic                   reset_dc,
    input  logic                   pll54_lockloss,
    input  logic                   pll_hdmi_lockloss,
    input  logic                   resync_event,
    output logic [COUNT_WIDTH-1:0] pll54_lockloss_count,
    output logic [COUNT_WIDTH-1:0] pll_hdmi_lockloss_count,
    output logic [COUNT_WIDTH-1:0] resync_count
);

    // counters wrap, the reader takes differences
    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            pll54_lockloss_count    <= '0;
            pll_hdmi_lockloss_count <= '0;
            resync_count            <= '0;
        end else begin
            if (pll54_lockloss) begin
                pll54_lockloss_count <= pll54_lockloss_count + 1'b1;
            end
            if (pll_hdmi_lockloss) begin
                pll_hdmi_lockloss_count <= pll_hdmi_lockloss_count + 1'b1;
            end
            if (resync_event) begin
                resync_count <= resync_count + 1'b1;
            end
        end
    end

endmodule

/* src/glow_pwm.sv */
`timescale 1ns/100ps

module glow_pwm import reset_ctrl_pkg::*; #(
    parameter int bit_pos = SLOW_GLOW_BIT
) (
    input  logic control_clock,
    input  logic reset_dc,
    output logic glow
);

    localparam int RAMP_W = bit_pos / 2;

    logic [bit_pos:0]  glow_count;
    logic [RAMP_W-1:0] ramp;
    logic [RAMP_W-1:0] phase;

    // top bit picks up or down slope of the triangle
    assign ramp  = glow_count[bit_pos] ? ~glow_count[bit_pos-1 -: RAMP_W]
                                       : glow_count[bit_pos-1 -: RAMP_W];
    assign phase = glow_count[bit_pos-RAMP_W-1 -: RAMP_W];

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            glow_count <= '0;
            glow       <= 1'b0;
        end else begin
            glow_count <= glow_count + 1'b1;
            // duty follows the ramp
            glow <= (phase < ramp);
        end
    end

endmodule

/* src/status_led_driver.sv */
`timescale 1ns/100ps

module status_led_driver import reset_ctrl_pkg::*; #(
    parameter int slow_glow_bit = SLOW_GLOW_BIT,
    parameter int fast_glow_bit = FAST_GLOW_BIT,
    parameter int blink_bit     = BLINK_BIT
) (
    input  logic      control_clock,
    input  logic      reset_dc,
    input  led_mode_e led_mode,
    input  logic      pll_hdmi_ready,
    input  logic      resync_active,
    input  logic      force_gen_active,
    input  logic      adv7513_ready,
    input  logic      dc_hold_low,
    input  logic      opt_hold_low,
    output logic      status_led_oe,
    output logic      status_led_level
);

    logic                slow_glow;
    logic                fast_glow;
    logic [blink_bit:0]  blink_count;
    led_status_e         led_status;

    glow_pwm #(.bit_pos(slow_glow_bit)) u_slow_glow (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .glow          (slow_glow)
    );

    glow_pwm #(.bit_pos(fast_glow_bit)) u_fast_glow (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .glow          (fast_glow)
    );

    // status priority, pll lock first
    always_comb begin
        if (!pll_hdmi_ready) led_status = ST_PLL_WAIT;
        else if (resync_active) led_status = ST_RESYNC;
        else if (force_gen_active) led_status = ST_FORCE_GEN;
        else if (adv7513_ready) led_status = ST_READY;
        else led_status = ST_CONFIGURING;
    end

    ////////////////////////////////////////////////////////////////////////////
    // pin drive, led is active low

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            blink_count      <= '0;
            status_led_oe    <= 1'b0;
            status_led_level <= 1'b0;
        end else begin
            blink_count <= blink_count + 1'b1;
            case (led_mode)
                LED_STATUS: begin
                    status_led_oe <= 1'b1;
                    case (led_status)
                        ST_PLL_WAIT:    status_led_level <= 1'b1;
                        ST_RESYNC:      status_led_level <= ~fast_glow;
                        ST_FORCE_GEN:   status_led_level <= blink_count[blink_bit] ? ~fast_glow
                                                                                   : 1'b1;
                        ST_READY:       status_led_level <= 1'b0;
                        ST_CONFIGURING: status_led_level <= ~slow_glow;
                        default:        status_led_level <= 1'b1;
                    endcase
                end
                LED_OPT_RESET: begin
                    status_led_oe    <= opt_hold_low;
                    status_led_level <= 1'b0;
                end
                LED_DC_RESET: begin
                    status_led_oe    <= dc_hold_low;
                    status_led_level <= 1'b0;
                end
                default: begin
                    status_led_oe    <= 1'b0;
                    status_led_level <= 1'b0;
                end
            endcase
        end
    end

    a_led_off_released: assert property (@(posedge control_clock) disable iff (reset_dc)
        led_mode == LED_OFF |=> !status_led_oe);

endmodule

/* src/console_reset_ctrl.sv */
`timescale 1ns/100ps

module console_reset_ctrl import reset_ctrl_pkg::*; #(
    parameter logic [COUNT_WIDTH-1:0] hold_cycles = HOLD_CYCLES_DEFAULT,
    parameter int slow_glow_bit = SLOW_GLOW_BIT,
    parameter int fast_glow_bit = FAST_GLOW_BIT,
    parameter int blink_bit     = BLINK_BIT
) (
    input  logic                   control_clock,
    input  logic                   reset_dc,
    input  logic                   pll54_locked,
    input  logic                   pll_hdmi_locked,
    input  logic                   resync,
    input  logic                   force_generate,
    input  logic                   adv7513_ready,
    input  led_mode_e              led_mode,
    input  logic                   dc_reset_request,
    input  logic                   opt_reset_request,
    output logic                   dc_nreset_low,
    output logic                   opt_nreset_low,
    output logic                   status_led_oe,
    output logic                   status_led_level,
    output logic [COUNT_WIDTH-1:0] pll54_lockloss_count,
    output logic [COUNT_WIDTH-1:0] pll_hdmi_lockloss_count,
    output logic [COUNT_WIDTH-1:0] resync_count
);

    logic pll_hdmi_ready;
    logic resync_active;
    logic force_gen_active;
    logic pll54_lockloss;
    logic pll_hdmi_lockloss;
    logic resync_event;

    ////////////////////////////////////////////////////////////////////////////
    // input side

    lock_event_detect u_lock_event_detect (
        .control_clock     (control_clock),
        .reset_dc          (reset_dc),
        .pll54_locked      (pll54_locked),
        .pll_hdmi_locked   (pll_hdmi_locked),
        .resync            (resync),
        .force_generate    (force_generate),
        .pll_hdmi_ready    (pll_hdmi_ready),
        .resync_active     (resync_active),
        .force_gen_active  (force_gen_active),
        .pll54_lockloss    (pll54_lockloss),
        .pll_hdmi_lockloss (pll_hdmi_lockloss),
        .resync_event      (resync_event)
    );

    ////////////////////////////////////////////////////////////////////////////
    // reset hold and event counts

    // console reset line
    reset_hold_timer #(.hold_cycles(hold_cycles)) u_dc_hold (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .request       (dc_reset_request),
        .hold_low      (dc_nreset_low)
    );

    // optional drive reset line
    reset_hold_timer #(.hold_cycles(hold_cycles)) u_opt_hold (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .request       (opt_reset_request),
        .hold_low      (opt_nreset_low)
    );

    event_counters u_event_counters (
        .control_clock           (control_clock),
        .reset_dc                (reset_dc),
        .pll54_lockloss          (pll54_lockloss),
        .pll_hdmi_lockloss       (pll_hdmi_lockloss),
        .resync_event            (resync_event),
        .pll54_lockloss_count    (pll54_lockloss_count),
        .pll_hdmi_lockloss_count (pll_hdmi_lockloss_count),
        .resync_count            (resync_count)
    );

    ////////////////////////////////////////////////////////////////////////////
    // output side

    status_led_driver #(
        .slow_glow_bit (slow_glow_bit),
        .fast_glow_bit (fast_glow_bit),
        .blink_bit     (blink_bit)
    ) u_status_led_driver (
        .control_clock    (control_clock),
        .reset_dc         (reset_dc),
        .led_mode         (led_mode),
        .pll_hdmi_ready   (pll_hdmi_ready),
        .resync_active    (resync_active),
        .force_gen_active (force_gen_active),
        .adv7513_ready    (adv7513_ready),
        .dc_hold_low      (dc_nreset_low),
        .opt_hold_low     (opt_nreset_low),
        .status_led_oe    (status_led_oe),
        .status_led_level (status_led_level)
    );

endmodule

/* dv/tb_console_reset_ctrl.sv */
`timescale 1ns/100ps

module tb_console_reset_ctrl import reset_ctrl_pkg::*; ();

    localparam int CLK_PERIOD    = 20;
    localparam int RESET_CYCLES  = 10;
    localparam int HOLD          = 40;
    localparam int IDLE          = HOLD + 2;
    localparam int MAX_EVENTS    = 12;
    localparam int STATUS_ROUNDS = 6;
    localparam int TEST_CYCLES   = RESET_CYCLES + 3 * (20 + HOLD + 4) + STATUS_ROUNDS * 8
                                   + MAX_EVENTS * 16 + 8;

    logic        control_clock = 1'b0;
    logic        reset_dc;
    logic        pll54_locked;
    logic        pll_hdmi_locked;
    logic        resync;
    logic        force_generate;
    logic        adv7513_ready;
    led_mode_e   led_mode;
    logic        dc_reset_request;
    logic        opt_reset_request;
    logic        dc_nreset_low;
    logic        opt_nreset_low;
    logic        status_led_oe;
    logic        status_led_level;
    logic [31:0] pll54_lockloss_count;
    logic [31:0] pll_hdmi_lockloss_count;
    logic [31:0] resync_count;

    int          seed = 32'hb510;
    int          errors = 0;
    int          cycles_compared = 0;
    int          r;
    int          n_events;
    logic [31:0] exp_pll54_drops = '0;
    logic [31:0] exp_hdmi_drops = '0;
    logic [31:0] exp_resyncs = '0;

    // cycle model of the synchronizers and hold lines
    logic [3:0]  sync_a;
    logic [3:0]  sync_b;
    int          dc_since;
    int          opt_since;
    logic        dc_hold_m;
    logic        opt_hold_m;
    // {level known, oe, level}
    logic [2:0]  exp_led;

    console_reset_ctrl #(
        .hold_cycles   (HOLD),
        .slow_glow_bit (4),
        .fast_glow_bit (4),
        .blink_bit     (3)
    ) DUT (.*);

    always #(CLK_PERIOD / 2) control_clock = ~control_clock;

    ////////////////////////////////////////////////////////////////////////////
    // reference model and comparison

    function automatic logic [2:0] expected_led(input led_mode_e mode, input logic hdmi_ready,
                                                input logic resync_on, input logic force_on,
                                                input logic tx_ready, input logic dc_hold,
                                                input logic opt_hold);
        logic [2:0] result;
        case (mode)
            LED_STATUS: begin
                if (!hdmi_ready) begin
                    result = 3'b111;
                end else if (resync_on || force_on || !tx_ready) begin
                    // glow cases leave only oe fixed
                    result = 3'b010;
                end else begin
                    result = 3'b110;
                end
            end
            LED_OPT_RESET: result = {1'b1, opt_hold, 1'b0};
            LED_DC_RESET:  result = {1'b1, dc_hold, 1'b0};
            default:       result = 3'b000;
        endcase
        return result;
    endfunction

    // line stays low until HOLD+1 cycles after the last request cycle
    assign dc_hold_m  = (dc_since <= HOLD);
    assign opt_hold_m = (opt_since <= HOLD);

    always @(posedge control_clock) begin
        if (reset_dc) begin
            sync_a    <= '0;
            sync_b    <= '0;
            dc_since  <= IDLE;
            opt_since <= IDLE;
            exp_led   <= 3'b100;
        end else begin
            sync_a <= {force_generate, resync, pll_hdmi_locked, pll54_locked};
            sync_b <= sync_a;
            if (dc_reset_request) begin
                dc_since <= 0;
            end else if (dc_since < IDLE) begin
                dc_since <= dc_since + 1;
            end
            if (opt_reset_request) begin
                opt_since <= 0;
            end else if (opt_since < IDLE) begin
                opt_since <= opt_since + 1;
            end
            exp_led <= expected_led(led_mode, sync_b[1], sync_b[2], sync_b[3], adv7513_ready,
                                    dc_hold_m, opt_hold_m);
        end
    end

    always @(negedge control_clock) begin
        cycles_compared++;
        if (dc_nreset_low !== dc_hold_m) report_bit("dc_nreset_low", dc_nreset_low, dc_hold_m);
        if (opt_nreset_low !== opt_hold_m) report_bit("opt_nreset_low", opt_nreset_low, opt_hold_m);
        if (status_led_oe !== exp_led[1]) report_bit("status_led_oe", status_led_oe, exp_led[1]);
        if (exp_led[2] && status_led_level !== exp_led[0]) begin
            report_bit("status_led_level", status_led_level, exp_led[0]);
        end
    end

    task automatic report_bit(input string name, input logic got, input logic exp);
        errors++;
        $display("CHECK FAILED at %0t ns: %s = %b, expected %b", $time, name, got, exp);
    endtask

    task automatic report_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        errors++;
        $display("CHECK FAILED at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus helpers

    // edge counts follow the levels that are driven
    task automatic apply_async(input logic p54, input logic hdmi, input logic rs, input logic fg);
        if (pll54_locked && !p54) exp_pll54_drops = exp_pll54_drops + 32'd1;
        if (pll_hdmi_locked && !hdmi) exp_hdmi_drops = exp_hdmi_drops + 32'd1;
        if (!resync && rs) exp_resyncs = exp_resyncs + 32'd1;
        pll54_locked    = p54;
        pll_hdmi_locked = hdmi;
        resync          = rs;
        force_generate  = fg;
    endtask

    task automatic hold_test(input logic opt_line);
        int   len;
        logic line;
        len = 1 + ({$random(seed)} % 20);
        if (opt_line) begin
            led_mode          = LED_OPT_RESET;
            opt_reset_request = 1'b1;
        end else begin
            led_mode         = LED_DC_RESET;
            dc_reset_request = 1'b1;
        end
        for (int k = 1; k <= len + HOLD + 1; k++) begin
            @(negedge control_clock);
            line = opt_line ? opt_nreset_low : dc_nreset_low;
            if (line !== (k <= len + HOLD)) begin
                report_bit(opt_line ? "opt_nreset_low" : "dc_nreset_low", line, k <= len + HOLD);
            end
            if (k == len) begin
                dc_reset_request  = 1'b0;
                opt_reset_request = 1'b0;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // tests

    initial begin
        reset_dc          = 1'b1;
        pll54_locked      = 1'b1;
        pll_hdmi_locked   = 1'b1;
        resync            = 1'b0;
        force_generate    = 1'b0;
        adv7513_ready     = 1'b0;
        led_mode          = LED_STATUS;
        dc_reset_request  = 1'b0;
        opt_reset_request = 1'b0;
        repeat (RESET_CYCLES) @(negedge control_clock);
        if (dc_nreset_low !== 1'b0) report_bit("dc_nreset_low", dc_nreset_low, 1'b0);
        if (opt_nreset_low !== 1'b0) report_bit("opt_nreset_low", opt_nreset_low, 1'b0);
        if (status_led_oe !== 1'b0) report_bit("status_led_oe", status_led_oe, 1'b0);
        if (pll54_lockloss_count !== 0) begin
            report_word("pll54_lockloss_count", pll54_lockloss_count, 0);
        end
        if (pll_hdmi_lockloss_count !== 0) begin
            report_word("pll_hdmi_lockloss_count", pll_hdmi_lockloss_count, 0);
        end
        if (resync_count !== 0) report_word("resync_count", resync_count, 0);
        reset_dc = 1'b0;

        hold_test(1'b0);
        hold_test(1'b1);

        // pin released in LED_OFF even while a reset is held
        led_mode         = LED_OFF;
        dc_reset_request = 1'b1;
        repeat (2) @(negedge control_clock);
        if (status_led_oe !== 1'b0) report_bit("status_led_oe", status_led_oe, 1'b0);
        dc_reset_request = 1'b0;
        repeat (HOLD + 4) @(negedge control_clock);

        led_mode = LED_STATUS;
        for (int i = 0; i < STATUS_ROUNDS; i++) begin
            r = $random(seed);
            apply_async(pll54_locked, 1'b0, r[0], r[1]);
            adv7513_ready = r[2];
            repeat (4) @(negedge control_clock);
            if (status_led_oe !== 1'b1) report_bit("status_led_oe", status_led_oe, 1'b1);
            if (status_led_level !== 1'b1) report_bit("status_led_level", status_led_level, 1'b1);
            apply_async(pll54_locked, 1'b1, 1'b0, 1'b0);
            adv7513_ready = 1'b1;
            repeat (4) @(negedge control_clock);
            if (status_led_oe !== 1'b1) report_bit("status_led_oe", status_led_oe, 1'b1);
            if (status_led_level !== 1'b0) report_bit("status_led_level", status_led_level, 1'b0);
        end

        n_events = 4 + ({$random(seed)} % 9);
        for (int i = 0; i < n_events; i++) begin
            r = {$random(seed)} % 3;
            apply_async(r != 0, r != 1, r == 2, 1'b0);
            repeat (8) @(negedge control_clock);
            apply_async(1'b1, 1'b1, 1'b0, 1'b0);
            repeat (8) @(negedge control_clock);
        end
        repeat (6) @(negedge control_clock);
        if (pll54_lockloss_count !== exp_pll54_drops) begin
            report_word("pll54_lockloss_count", pll54_lockloss_count, exp_pll54_drops);
        end
        if (pll_hdmi_lockloss_count !== exp_hdmi_drops) begin
            report_word("pll_hdmi_lockloss_count", pll_hdmi_lockloss_count, exp_hdmi_drops);
        end
        if (resync_count !== exp_resyncs) report_word("resync_count", resync_count, exp_resyncs);

        $display("errors: %0d, cycles compared: %0d", errors, cycles_compared);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #((TEST_CYCLES * 2 + 1000) * CLK_PERIOD);
        $display("timeout: tests did not complete in %0d cycles", TEST_CYCLES * 2 + 1000);
        $display("errors: %0d, cycles compared: %0d", errors, cycles_compared);
        $display("Finished with errors");
        $finish;
    end

endmodule

/* sources.f */
src/reset_ctrl_pkg.sv
src/lock_event_detect.sv
src/reset_hold_timer.sv
src/event_counters.sv
src/glow_pwm.sv
src/status_led_driver.sv
src/console_reset_ctrl.sv
dv/tb_console_reset_ctrl.sv

/* run.sh */
#!/bin/sh
# build and run with Verilator, then scan the log for failure
verilator --binary --timing --assert -f sources.f --top-module tb_console_reset_ctrl \
    -o sim_console_reset_ctrl > build.log 2>&1 \
    && ./obj_dir/sim_console_reset_ctrl > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Finished with errors" sim.log && { echo "simulation FAILED"; exit 1; } \
    || { echo "simulation passed"; exit 0; }
